// ==== src/lcd_pkg.sv ====
// 16x2 HD44780-style text only; both pages fixed at build time, write-only bus, ASCII codes
`default_nettype none

package lcd_pkg;

  // bus and position types
  typedef logic [7:0] lcd_byte_t;  // command or character
  typedef logic [3:0] lcd_col_t;   // column 0..15
  typedef logic       lcd_row_t;   // line 1 or line 2
  typedef logic       lcd_page_t;  // which stored page

  localparam int LCD_COLS = 16;

  // init sequence, sent once after reset
  localparam lcd_byte_t CMD_FUNCTION_SET = 8'h38;  // 8-bit bus, 2 lines, 5x7 font
  localparam lcd_byte_t CMD_CLEAR        = 8'h01;
  localparam lcd_byte_t CMD_ENTRY_MODE   = 8'h06;  // cursor moves right, no shift
  localparam lcd_byte_t CMD_DISPLAY_ON   = 8'h0C;  // display on, cursor off

  // DDRAM address commands
  localparam lcd_byte_t CMD_LINE1_ADDR = 8'h80;
  localparam lcd_byte_t CMD_LINE2_ADDR = 8'hC0;  // 80h + 40h

  // page texts, leftmost character in bits 127:120
  // page 0 centred
  localparam logic [127:0] PAGE0_ROW0 = "  I like FPGA!  ";
  localparam logic [127:0] PAGE0_ROW1 = "  hello world!  ";

  // page 1 right-aligned, lines swapped
  localparam logic [127:0] PAGE1_ROW0 = "    hello world!";
  localparam logic [127:0] PAGE1_ROW1 = "    I like FPGA!";

  // write period is 2**TICK_BITS clocks
  // 16 bits gives about 1.3 ms per write at 50 MHz
  localparam int TICK_BITS_DEFAULT = 16;

  // whole frames shown before the page flips
  localparam int PAGE_FRAMES_DEFAULT = 8;

endpackage

`default_nettype wire

// ==== src/lcd_text_if.sv ====
// combinational lookup only, no handshake; the store must answer in the same cycle
`default_nettype none

interface lcd_text_if;
  import lcd_pkg::*;

  lcd_page_t page;       // from the page scheduler
  lcd_row_t  row;        // from the sequencer
  lcd_col_t  col;
  lcd_byte_t char_code;  // back from the store

  modport scheduler (output page);

  modport sequencer (
    output row,
    output col,
    input  char_code
  );

  modport store (input page, input row, input col, output char_code);

endinterface

`default_nettype wire

// ==== src/lcd_write_timer.sv ====
// free-running pacing; TICK_BITS must be at least 2 and sized for the LCD's minimum enable width
`default_nettype none

module lcd_write_timer #(
  parameter int TICK_BITS = lcd_pkg::TICK_BITS_DEFAULT
) (
  input  logic sysclk,
  input  logic rst_n,
  output logic step,
  output logic lcd_en
);

  logic [TICK_BITS-1:0] tick_cnt;

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;  // wraps every 2**TICK_BITS
    end
  end

  assign lcd_en = tick_cnt[TICK_BITS-1];  // high for the upper half period

  // last count before the MSB sets, so the sequencer loads on the rising edge
  assign step = (tick_cnt == {1'b0, {(TICK_BITS-1){1'b1}}});

  // strobe always sits in the low half and leads the enable rise by one clock
  a_step_leads_en : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    step |-> !lcd_en ##1 lcd_en
  );

endmodule

`default_nettype wire

// ==== src/lcd_text_rom.sv ====
// fixed text only, two pages of two rows; column 0 is the top byte of each row constant
`default_nettype none

module lcd_text_rom (
  lcd_text_if.store text
);
  import lcd_pkg::*;

  logic [127:0] row_text;
  int unsigned  byte_idx;

  // pick the row string for the current page
  always_comb begin
    case ({text.page, text.row})
      2'b00:   row_text = PAGE0_ROW0;
      2'b01:   row_text = PAGE0_ROW1;
      2'b10:   row_text = PAGE1_ROW0;
      default: row_text = PAGE1_ROW1;
    endcase
  end

  // col 0 is the leftmost char, which sits in the top byte
  always_comb begin
    byte_idx = LCD_COLS - 1 - int'(text.col);
  end

  assign text.char_code = row_text[8*byte_idx +: 8];

endmodule

`default_nettype wire

// ==== src/lcd_page_scheduler.sv ====
// PAGE_FRAMES must be at least 1; a page flip takes effect only between frames
`default_nettype none

module lcd_page_scheduler #(
  parameter int PAGE_FRAMES = lcd_pkg::PAGE_FRAMES_DEFAULT
) (
  input  logic                sysclk,
  input  logic                rst_n,
  input  logic                frame_done,
  lcd_text_if.scheduler       text
);

  logic [$clog2(PAGE_FRAMES+1)-1:0] frame_cnt;  // frames shown on the current page

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
      text.page <= 1'b0;
    end else if (frame_done) begin
      if (frame_cnt == $bits(frame_cnt)'(PAGE_FRAMES - 1)) begin
        frame_cnt <= '0;
        text.page <= ~text.page;  // other page from the next line-1 char on
      end else begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  // page must never flip mid-frame
  a_page_at_frame_end : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    $changed(text.page) |-> $past(frame_done)
  );

endmodule

`default_nettype wire

// ==== src/lcd_sequencer.sv ====
// write-only, no busy-flag polling; assumes each step period covers the slowest LCD command
`default_nettype none

module lcd_sequencer (
  input  logic               sysclk,
  input  logic               rst_n,
  input  logic               step,
  lcd_text_if.sequencer      text,
  output logic               frame_done,
  output logic               lcd_rs,
  output lcd_pkg::lcd_byte_t lcd_data
);
  import lcd_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,  // after reset, nothing written yet
    ST_INIT,  // one of the four init commands
    ST_ADDR,  // line address command
    ST_CHAR   // character at row/col
  } state_t;

  // registers describe the write currently on the bus
  state_t    state, state_nxt;
  logic [1:0] init_idx, init_idx_nxt;
  lcd_row_t  row, row_nxt;
  lcd_col_t  col, col_nxt;
  logic      rs_nxt;
  lcd_byte_t data_nxt;

  always_comb begin
    state_nxt    = state;
    init_idx_nxt = init_idx;
    row_nxt      = row;
    col_nxt      = col;
    case (state)
      ST_IDLE: begin
        state_nxt    = ST_INIT;
        init_idx_nxt = 2'd0;
      end
      ST_INIT: begin
        if (init_idx == 2'd3) begin
          state_nxt = ST_ADDR;
          row_nxt   = 1'b0;  // first frame starts on line 1
        end else begin
          init_idx_nxt = init_idx + 2'd1;
        end
      end
      ST_ADDR: begin
        state_nxt = ST_CHAR;
        col_nxt   = '0;
      end
      default: begin  // ST_CHAR
        if (col == lcd_col_t'(LCD_COLS - 1)) begin
          state_nxt = ST_ADDR;
          row_nxt   = ~row;  // line 2 after line 1 and back again
        end else begin
          col_nxt = col + 1'b1;
        end
      end
    endcase
  end

  // look up the character for the write being prepared
  assign text.row = row_nxt;
  assign text.col = col_nxt;

  // bus value for the next write
  always_comb begin
    rs_nxt   = 1'b0;
    data_nxt = '0;
    case (state_nxt)
      ST_INIT: begin
        case (init_idx_nxt)
          2'd0:    data_nxt = CMD_FUNCTION_SET;
          2'd1:    data_nxt = CMD_CLEAR;
          2'd2:    data_nxt = CMD_ENTRY_MODE;
          default: data_nxt = CMD_DISPLAY_ON;
        endcase
      end
      ST_ADDR: data_nxt = row_nxt ? CMD_LINE2_ADDR : CMD_LINE1_ADDR;
      ST_CHAR: begin
        rs_nxt   = 1'b1;  // data register
        data_nxt = text.char_code;
      end
      default: data_nxt = '0;
    endcase
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      init_idx <= '0;
      row      <= 1'b0;
      col      <= '0;
      lcd_rs   <= 1'b0;
      lcd_data <= '0;
    end else if (step) begin
      state    <= state_nxt;
      init_idx <= init_idx_nxt;
      row      <= row_nxt;
      col      <= col_nxt;
      lcd_rs   <= rs_nxt;
      lcd_data <= data_nxt;
    end
  end

  // last line-2 char going over to the line-1 address
  assign frame_done = step && (state == ST_CHAR) && row
                      && (col == lcd_col_t'(LCD_COLS - 1));

  // bus only moves right after a timer strobe
  a_bus_on_step : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    !$stable({lcd_rs, lcd_data}) |-> $past(step)
  );

endmodule

`default_nettype wire

// ==== src/lcd_display_top.sv ====
// write-only 8-bit LCD bus; R/W pin, power and backlight are tied off outside this block
`default_nettype none

module lcd_display_top #(
  parameter int TICK_BITS   = lcd_pkg::TICK_BITS_DEFAULT,
  parameter int PAGE_FRAMES = lcd_pkg::PAGE_FRAMES_DEFAULT
) (
  input  logic               sysclk,
  input  logic               rst_n,
  output logic               lcd_en,
  output logic               lcd_rs,
  output lcd_pkg::lcd_byte_t lcd_data
);

  logic step;        // one clock before each enable rise
  logic frame_done;  // end of a full two-line frame

  lcd_text_if text_if ();

  lcd_write_timer #(
    .TICK_BITS (TICK_BITS)
  ) u_lcd_write_timer (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .step   (step),
    .lcd_en (lcd_en)
  );

  lcd_text_rom u_lcd_text_rom (
    .text (text_if.store)
  );

  lcd_page_scheduler #(
    .PAGE_FRAMES (PAGE_FRAMES)
  ) u_lcd_page_scheduler (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .frame_done (frame_done),
    .text       (text_if.scheduler)
  );

  lcd_sequencer u_lcd_sequencer (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .step       (step),
    .text       (text_if.sequencer),
    .frame_done (frame_done),
    .lcd_rs     (lcd_rs),
    .lcd_data   (lcd_data)
  );

endmodule

`default_nettype wire

// ==== verification/tb_lcd_display.sv ====
// reads verification/lcd_stimulus.txt from the project root; built for TICK_BITS 4, PAGE_FRAMES 2
`default_nettype none

module tb_lcd_display;
  timeunit 1ns;
  timeprecision 100ps;
  import lcd_pkg::*;

  localparam int TICK_BITS    = 4;
  localparam int PAGE_FRAMES  = 2;
  localparam int T            = 2**TICK_BITS;  // clocks per write
  localparam int CLK_NS       = 100;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY  = 1;  // ns after the rising edge
  localparam int FRAME_WRITES = 2 * (LCD_COLS + 1);

  logic      sysclk;
  logic      rst_n;
  logic      lcd_en;
  logic      lcd_rs;
  lcd_byte_t lcd_data;

  logic [127:0] stim_mem [0:10];
  logic [8:0]   wr_q [$];  // {rs, data} per enable rise
  int           err_cnt;
  int           timing_err;
  int           tests_run;
  int           tests_failed;
  int           edge_cnt;  // rising edges since reset release
  longint       watchdog_ns;

  lcd_display_top #(
    .TICK_BITS   (TICK_BITS),
    .PAGE_FRAMES (PAGE_FRAMES)
  ) u_lcd_display_top (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .lcd_en   (lcd_en),
    .lcd_rs   (lcd_rs),
    .lcd_data (lcd_data)
  );

  initial begin
    sysclk = 1'b0;
    forever #(CLK_NS / 2) sysclk = ~sysclk;
  end

  always @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) edge_cnt <= 0;
    else edge_cnt <= edge_cnt + 1;
  end

  task automatic check_rs(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h at %0t ns", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic check_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h at %0t ns", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR %s: got %0h clocks, expected %0h at %0t ns", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  function automatic int hex_nibble(input byte c);
    if (c >= "0" && c <= "9") return c - "0";
    if (c >= "a" && c <= "f") return c - "a" + 10;
    if (c >= "A" && c <= "F") return c - "A" + 10;
    return -1;
  endfunction

  // one value per line, spaces inside a value ignored, rest of line after / skipped
  task automatic load_stimulus(output int loaded);
    int           fd;
    int           nib;
    int           digits;
    string        line;
    logic [127:0] value;
    loaded = 0;
    fd = $fopen("verification/lcd_stimulus.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd) && loaded < $size(stim_mem)) begin
      line = "";
      void'($fgets(line, fd));
      value  = '0;
      digits = 0;
      for (int i = 0; i < line.len(); i++) begin
        if (line.getc(i) == "/") break;
        nib = hex_nibble(line.getc(i));
        if (nib >= 0) begin
          value = {value[123:0], 4'(nib)};
          digits++;
        end
      end
      if (digits > 0) begin
        stim_mem[loaded] = value;
        loaded++;
      end
    end
    $fclose(fd);
  endtask

  // sampled mid-cycle, away from the edge that moves the bus
  always @(negedge sysclk) begin : enable_monitor
    logic      en_prev;
    int        last_rise;
    int        err_before;
    logic      held_rs;
    lcd_byte_t held_data;
    err_before = err_cnt;
    if (!rst_n) begin
      en_prev   = 1'b0;
      last_rise = -1;  // first rise after release still to come
    end else begin
      if (lcd_en && !en_prev) begin
        if (last_rise < 0) check_cycles("first lcd_en rise", edge_cnt, T / 2);
        else check_cycles("lcd_en period", edge_cnt - last_rise, T);
        last_rise = edge_cnt;
        held_rs   = lcd_rs;
        held_data = lcd_data;
        wr_q.push_back({lcd_rs, lcd_data});
      end else if (lcd_en) begin
        check_rs("lcd_rs", lcd_rs, held_rs);  // must hold while enable is high
        check_byte("lcd_data", lcd_data, held_data);
      end
      en_prev = lcd_en;
    end
    timing_err += err_cnt - err_before;
  end

  task automatic expect_write(input logic exp_rs, input lcd_byte_t exp_data);
    logic [8:0] w;
    while (wr_q.size() == 0) @(posedge sysclk);
    w = wr_q.pop_front();
    check_rs("lcd_rs", w[8], exp_rs);
    check_byte("lcd_data", w[7:0], exp_data);
  endtask

  function automatic lcd_byte_t char_of(input int page, input int row, input int col);
    logic [127:0] text;
    text = stim_mem[6 + 2 * page + row] << (8 * col);  // wanted column moved to the top byte
    return text[127:120];
  endfunction

  // address then 16 chars, twice; stops early after the given write count
  task automatic check_frame(input int page, input int writes);
    int row;
    int k;
    for (int pos = 0; pos < writes; pos++) begin
      row = pos / (LCD_COLS + 1);
      k   = pos % (LCD_COLS + 1);
      if (k == 0) expect_write(1'b0, stim_mem[4 + row][7:0]);
      else expect_write(1'b1, char_of(page, row, k - 1));
    end
  endtask

  task automatic report_test(input string name, input int errors);
    tests_run++;
    if (errors == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors);
    end
  endtask

  initial begin : watchdog
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("timeout: the LCD write stream stopped before the tests finished");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    int start;
    int cycles;
    int loaded;
    rst_n = 1'b0;
    load_stimulus(loaded);
    cycles = int'(stim_mem[10]);
    if (loaded != $size(stim_mem) || cycles < 1) begin
      $display("stimulus file missing, short, or its page cycle count is not positive");
      err_cnt++;
      cycles = 1;
    end
    // two init runs, all full frames, the partial frame and a few spare writes
    watchdog_ns = longint'(8 + FRAME_WRITES * (5 * PAGE_FRAMES + 2 * PAGE_FRAMES * cycles)
                           + 10 + 8) * T * CLK_NS
                  + 2 * RESET_CYCLES * CLK_NS;
    repeat (RESET_CYCLES) @(posedge sysclk);
    #DRIVE_DELAY rst_n = 1'b1;

    start = err_cnt;
    for (int i = 0; i < 4; i++) expect_write(1'b0, stim_mem[i][7:0]);
    report_test("init commands", err_cnt - start);

    start = err_cnt;
    check_frame(0, FRAME_WRITES);
    report_test("first frame on page 0", err_cnt - start);

    start = err_cnt;
    for (int f = 1; f < PAGE_FRAMES; f++) check_frame(0, FRAME_WRITES);
    for (int f = 0; f < PAGE_FRAMES; f++) check_frame(1, FRAME_WRITES);
    report_test("page switch at frame count", err_cnt - start);

    start = err_cnt;
    for (int c = 0; c < cycles; c++) begin
      for (int f = 0; f < 2 * PAGE_FRAMES; f++) check_frame(f / PAGE_FRAMES, FRAME_WRITES);
    end
    report_test("repeated page cycles", err_cnt - start);

    report_test("enable timing", timing_err);

    start = err_cnt;
    for (int f = 0; f < PAGE_FRAMES; f++) check_frame(0, FRAME_WRITES);
    for (int f = 1; f < PAGE_FRAMES; f++) check_frame(1, FRAME_WRITES);
    check_frame(1, 10);  // last page-1 frame, part way into line 1
    @(posedge sysclk);
    #DRIVE_DELAY rst_n = 1'b0;
    wr_q.delete();
    repeat (RESET_CYCLES) begin
      @(negedge sysclk);
      check_rs("lcd_en", lcd_en, 1'b0);
      check_rs("lcd_rs", lcd_rs, 1'b0);
      check_byte("lcd_data", lcd_data, 8'h00);
    end
    @(posedge sysclk);
    #DRIVE_DELAY rst_n = 1'b1;
    for (int i = 0; i < 4; i++) expect_write(1'b0, stim_mem[i][7:0]);
    for (int f = 0; f < PAGE_FRAMES; f++) check_frame(0, FRAME_WRITES);
    check_frame(1, FRAME_WRITES);  // page and frame count both start over
    report_test("reset in mid-frame", err_cnt - start);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/lcd_pkg.sv
src/lcd_text_if.sv
src/lcd_write_timer.sv
src/lcd_text_rom.sv
src/lcd_page_scheduler.sv
src/lcd_sequencer.sv
src/lcd_display_top.sv
verification/tb_lcd_display.sv

// ==== Makefile ====
# Verilator build and run of the LCD display testbench
TOP     := tb_lcd_display
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f verilog.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/lcd_stimulus.txt ====
// one hex value per line: 0-3 init commands, 4-5 line 1 and line 2 addresses
// 6-9 row texts (page 0 row 0, page 0 row 1, page 1 row 0, page 1 row 1), 10 page cycles
38  // function set
01  // clear
06  // entry mode
0C  // display on
80  // line 1 address
C0  // line 2 address
20204920 6C696B65 20465047 41212020
20206865 6C6C6F20 776F726C 64212020
20202020 68656C6C 6F20776F 726C6421
20202020 4920 6C69 6B65 2046 5047 4121
2   // page cycles to run
